// File: include/flow_config.svh
`ifndef FLOW_CONFIG_SVH
`define FLOW_CONFIG_SVH

// Payload bits carried by each word
`define FLOW_DATA_W 8

// Destination field above the payload
`define FLOW_DEST_W 2

// Output FIFOs behind the router
`define FLOW_PORTS 4

// Input FIFO depth
`define FLOW_IN_DEPTH 8

// Depth of each output FIFO
`define FLOW_OUT_DEPTH 4

// Counts and thresholds, wide enough for the deepest FIFO
`define FLOW_CNT_W 4

`endif

// File: source/flow_pkg.sv
`include "flow_config.svh"

package flow_pkg;

  typedef logic [`FLOW_DATA_W-1:0] payload_t;

  typedef logic [`FLOW_DEST_W-1:0] dest_t;

  // Destination in the upper bits, payload below
  typedef logic [`FLOW_DEST_W+`FLOW_DATA_W-1:0] word_t;

  typedef logic [`FLOW_CNT_W-1:0] count_t;

  typedef logic [`FLOW_PORTS-1:0] port_mask_t;

  // Bit 0 is the input FIFO, bits 1 and up the output FIFOs
  typedef logic [`FLOW_PORTS:0] status_t;

  // One-hot controller states
  typedef enum logic [6:0] {
    RESET      = 7'b000_0001,
    ERROR      = 7'b000_0010,
    INIT       = 7'b000_0100,
    IDLE_EMPTY = 7'b000_1000,
    PAUSE      = 7'b001_0000,
    RESUME     = 7'b010_0000,
    ACTIVE     = 7'b100_0000
  } ctrl_state_t;

endpackage

// File: source/flow_fifo.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module flow_fifo #(
  parameter int DEPTH = `FLOW_OUT_DEPTH
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  flow_pkg::word_t  push_data,
  input  logic             pop,
  output flow_pkg::word_t  pop_data,
  input  flow_pkg::count_t thresh_afull,
  input  flow_pkg::count_t thresh_aempty,
  output logic             full,
  output logic             almost_full,
  output logic             empty,
  output logic             almost_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  flow_pkg::word_t  mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  flow_pkg::count_t count;
  logic             do_push;
  logic             do_pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Status flags straight from the occupancy
  assign full         = (count == flow_pkg::count_t'(DEPTH));
  assign empty        = (count == '0);
  assign almost_full  = (count >= thresh_afull);
  assign almost_empty = !empty && (count <= thresh_aempty);

  // Push into a full FIFO or pop from an empty one is dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head word is visible without a read latency
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/vc_router.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module vc_router (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fwd_en,
  input  flow_pkg::port_mask_t pause,
  input  logic                 in_empty,
  input  flow_pkg::word_t      in_data,
  output logic                 in_pop,
  input  flow_pkg::port_mask_t out_full,
  output flow_pkg::port_mask_t out_push,
  output flow_pkg::word_t      out_data
);

  flow_pkg::dest_t      dest;
  flow_pkg::port_mask_t dest_mask;
  flow_pkg::port_mask_t blocked;
  logic                 move;

  // Destination field of the head word
  assign dest = in_data[`FLOW_DATA_W +: `FLOW_DEST_W];

  // One-hot select of the target output
  always_comb begin
    dest_mask = '0;
    for (int i = 0; i < `FLOW_PORTS; i++) begin
      if (dest == flow_pkg::dest_t'(i)) begin
        dest_mask[i] = 1'b1;
      end
    end
  end

  // A port is blocked while full, paused, or with a push still in flight,
  // since its full flag does not yet count that word
  assign blocked = out_full | pause | out_push;

  // Head-of-line stall keeps per-destination order
  assign move   = fwd_en && !in_empty && ((dest_mask & blocked) == '0);
  assign in_pop = move;

  always_ff @(posedge clk) begin
    if (!rst) begin
      out_push <= '0;
    end else if (move) begin
      out_push <= dest_mask;
    end else begin
      out_push <= '0;
    end
  end

  // Word held for the push cycle
  always_ff @(posedge clk) begin
    if (move) begin
      out_data <= in_data;
    end
  end

endmodule

// File: source/flow_ctrl.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module flow_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 cfg_wr,
  input  flow_pkg::count_t     cfg_afull,
  input  flow_pkg::count_t     cfg_aempty,
  input  flow_pkg::status_t    full,
  input  flow_pkg::status_t    almost_full,
  input  flow_pkg::status_t    empty,
  input  flow_pkg::status_t    almost_empty,
  output flow_pkg::count_t     thresh_afull,
  output flow_pkg::count_t     thresh_aempty,
  output logic                 fwd_en,
  output flow_pkg::port_mask_t pause,
  output logic                 resume,
  output logic                 idle,
  output logic                 error_full
);

  flow_pkg::ctrl_state_t state;
  flow_pkg::ctrl_state_t next_state;
  flow_pkg::port_mask_t  out_afull;
  logic                  any_full;
  logic                  any_out_afull;

  // Output FIFOs sit above the input FIFO in the status vectors
  assign out_afull     = almost_full[`FLOW_PORTS:1];
  assign any_out_afull = |out_afull;
  assign any_full      = |full;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= flow_pkg::RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      flow_pkg::ACTIVE: begin
        if (any_full) begin
          next_state = flow_pkg::ERROR;
        end else if (any_out_afull) begin
          next_state = flow_pkg::PAUSE;
        end else if (empty[0]) begin
          next_state = flow_pkg::IDLE_EMPTY;
        end else if (almost_empty[0]) begin
          next_state = flow_pkg::RESUME;
        end else begin
          next_state = flow_pkg::ACTIVE;
        end
      end
      flow_pkg::RESUME: begin
        next_state = any_full ? flow_pkg::ERROR : flow_pkg::ACTIVE;
      end
      flow_pkg::PAUSE: begin
        next_state = any_out_afull ? flow_pkg::PAUSE : flow_pkg::ACTIVE;
      end
      flow_pkg::IDLE_EMPTY: begin
        next_state = empty[0] ? flow_pkg::IDLE_EMPTY : flow_pkg::ACTIVE;
      end
      flow_pkg::INIT: begin
        next_state = start ? flow_pkg::IDLE_EMPTY : flow_pkg::INIT;
      end
      // Only a reset leaves ERROR
      flow_pkg::ERROR: begin
        next_state = flow_pkg::ERROR;
      end
      flow_pkg::RESET: begin
        next_state = rst ? flow_pkg::INIT : flow_pkg::RESET;
      end
      // Recover from a corrupted encoding
      default: begin
        next_state = flow_pkg::RESET;
      end
    endcase
  end

  // Outputs decoded from the next state, one cycle behind the decision
  always_ff @(posedge clk) begin
    if (!rst) begin
      fwd_en     <= 1'b0;
      pause      <= '0;
      resume     <= 1'b0;
      idle       <= 1'b0;
      error_full <= 1'b1;
    end else begin
      fwd_en <= (next_state == flow_pkg::ACTIVE) ||
                (next_state == flow_pkg::RESUME) ||
                (next_state == flow_pkg::IDLE_EMPTY);
      pause      <= (next_state == flow_pkg::PAUSE) ? out_afull : '0;
      resume     <= (next_state == flow_pkg::RESUME);
      idle       <= (next_state == flow_pkg::IDLE_EMPTY);
      error_full <= (next_state == flow_pkg::ERROR) ||
                    (next_state == flow_pkg::RESET);
    end
  end

  // Thresholds shared by all five FIFOs, writable in INIT only
  always_ff @(posedge clk) begin
    if (!rst) begin
      thresh_afull  <= flow_pkg::count_t'(`FLOW_OUT_DEPTH - 1);
      thresh_aempty <= flow_pkg::count_t'(1);
    end else if (cfg_wr && (state == flow_pkg::INIT)) begin
      thresh_afull  <= cfg_afull;
      thresh_aempty <= cfg_aempty;
    end
  end

endmodule

// File: source/flow_top.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module flow_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 cfg_wr,
  input  flow_pkg::count_t     cfg_afull,
  input  flow_pkg::count_t     cfg_aempty,
  input  logic                 in_push,
  input  flow_pkg::word_t      in_word,
  input  flow_pkg::port_mask_t out_pop,
  output flow_pkg::payload_t   out_data0,
  output flow_pkg::payload_t   out_data1,
  output flow_pkg::payload_t   out_data2,
  output flow_pkg::payload_t   out_data3,
  output flow_pkg::port_mask_t out_empty,
  output flow_pkg::port_mask_t pause,
  output logic                 resume,
  output logic                 idle,
  output logic                 error_full
);

  // Input FIFO side
  flow_pkg::word_t      in_head;
  logic                 in_pop;
  logic                 in_full;
  logic                 in_afull;
  logic                 in_empty;
  logic                 in_aempty;

  // Router to output FIFOs
  flow_pkg::port_mask_t rt_push;
  flow_pkg::word_t      rt_data;
  flow_pkg::word_t      out_word [`FLOW_PORTS];
  flow_pkg::port_mask_t out_full;
  flow_pkg::port_mask_t out_afull;
  flow_pkg::port_mask_t out_aempty;

  // Controller links
  flow_pkg::status_t    st_full;
  flow_pkg::status_t    st_afull;
  flow_pkg::status_t    st_empty;
  flow_pkg::status_t    st_aempty;
  flow_pkg::count_t     thresh_afull;
  flow_pkg::count_t     thresh_aempty;
  logic                 fwd_en;

  flow_fifo #(
    .DEPTH(`FLOW_IN_DEPTH)
  ) in_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (in_push),
    .push_data    (in_word),
    .pop          (in_pop),
    .pop_data     (in_head),
    .thresh_afull (thresh_afull),
    .thresh_aempty(thresh_aempty),
    .full         (in_full),
    .almost_full  (in_afull),
    .empty        (in_empty),
    .almost_empty (in_aempty)
  );

  vc_router router (
    .clk     (clk),
    .rst     (rst),
    .fwd_en  (fwd_en),
    .pause   (pause),
    .in_empty(in_empty),
    .in_data (in_head),
    .in_pop  (in_pop),
    .out_full(out_full),
    .out_push(rt_push),
    .out_data(rt_data)
  );

  for (genvar i = 0; i < `FLOW_PORTS; i++) begin : g_out
    flow_fifo #(
      .DEPTH(`FLOW_OUT_DEPTH)
    ) out_fifo (
      .clk          (clk),
      .rst          (rst),
      .push         (rt_push[i]),
      .push_data    (rt_data),
      .pop          (out_pop[i]),
      .pop_data     (out_word[i]),
      .thresh_afull (thresh_afull),
      .thresh_aempty(thresh_aempty),
      .full         (out_full[i]),
      .almost_full  (out_afull[i]),
      .empty        (out_empty[i]),
      .almost_empty (out_aempty[i])
    );
  end

  // Input FIFO in bit 0, outputs above
  assign st_full   = {out_full, in_full};
  assign st_afull  = {out_afull, in_afull};
  assign st_empty  = {out_empty, in_empty};
  assign st_aempty = {out_aempty, in_aempty};

  flow_ctrl ctrl (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .cfg_wr       (cfg_wr),
    .cfg_afull    (cfg_afull),
    .cfg_aempty   (cfg_aempty),
    .full         (st_full),
    .almost_full  (st_afull),
    .empty        (st_empty),
    .almost_empty (st_aempty),
    .thresh_afull (thresh_afull),
    .thresh_aempty(thresh_aempty),
    .fwd_en       (fwd_en),
    .pause        (pause),
    .resume       (resume),
    .idle         (idle),
    .error_full   (error_full)
  );

  // Payloads leave without their destination bits
  assign out_data0 = out_word[0][`FLOW_DATA_W-1:0];
  assign out_data1 = out_word[1][`FLOW_DATA_W-1:0];
  assign out_data2 = out_word[2][`FLOW_DATA_W-1:0];
  assign out_data3 = out_word[3][`FLOW_DATA_W-1:0];

endmodule

// File: tests/flow_clkgen.sv
`timescale 1ns/1ps

module flow_clkgen (
  input  logic reset_req,
  output logic clk,
  output logic rst
);

  logic por_done;

  initial clk = 1'b0;

  always #5 clk = ~clk;

  // Power-on reset held low for 8 clock cycles
  initial begin
    por_done = 1'b0;
    repeat (8) @(posedge clk);
    por_done <= 1'b1;
  end

  // The testbench can pull reset low again later
  assign rst = por_done && !reset_req;

endmodule

// File: tests/flow_checker.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module flow_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_push,
  input  flow_pkg::word_t      in_word,
  input  flow_pkg::port_mask_t out_pop,
  input  flow_pkg::payload_t   out_data0,
  input  flow_pkg::payload_t   out_data1,
  input  flow_pkg::payload_t   out_data2,
  input  flow_pkg::payload_t   out_data3,
  input  flow_pkg::port_mask_t out_empty,
  output int                   mismatches
);

  // Expected payloads per destination, in push order
  flow_pkg::payload_t   exp_q [`FLOW_PORTS][$];
  flow_pkg::port_mask_t prev_empty;
  int                   err_count = 0;

  assign mismatches = err_count;

  function automatic flow_pkg::payload_t port_data(input int p);
    flow_pkg::payload_t v;
    case (p)
      0:       v = out_data0;
      1:       v = out_data1;
      2:       v = out_data2;
      default: v = out_data3;
    endcase
    return v;
  endfunction

  always @(posedge clk) begin : compare
    flow_pkg::payload_t want;
    flow_pkg::dest_t    d;
    if (!rst) begin
      // FIFO contents are lost on reset
      for (int p = 0; p < `FLOW_PORTS; p++) begin
        exp_q[p].delete();
      end
    end else begin
      for (int p = 0; p < `FLOW_PORTS; p++) begin
        if (out_pop[p] && !out_empty[p]) begin
          if (exp_q[p].size() == 0) begin
            $display("Port %0d gave a word at %0t although none was routed to it", p, $time);
            err_count++;
          end else begin
            want = exp_q[p].pop_front();
            if (port_data(p) !== want) begin
              $display("[FAIL] %0t out_data%0d got 0x%h expected 0x%h",
                       $time, p, port_data(p), want);
              err_count++;
            end
          end
        end
        // A port may only turn non-empty when a word is due there
        if (prev_empty[p] === 1'b1 && out_empty[p] === 1'b0 && exp_q[p].size() == 0) begin
          $display("Port %0d became non-empty at %0t with nothing pushed for it", p, $time);
          err_count++;
        end
      end
      if (in_push) begin
        d = in_word[`FLOW_DATA_W +: `FLOW_DEST_W];
        exp_q[d].push_back(in_word[`FLOW_DATA_W-1:0]);
      end
    end
    prev_empty <= out_empty;
  end

endmodule

// File: tests/flow_sva.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module flow_sva (
  input logic       clk,
  input logic       rst,
  input logic [6:0] state,
  input logic       resume,
  input logic       error_full
);

  int fail_count = 0;

  // Error flag holds until the next reset once set after reset release
  a_error_sticky: assert property (@(posedge clk) disable iff (!rst)
    (error_full && $past(rst)) |=> error_full)
    else begin
      fail_count++;
      $error("error_full dropped before reset");
    end

  a_resume_pulse: assert property (@(posedge clk) disable iff (!rst)
    resume |=> !resume)
    else begin
      fail_count++;
      $error("resume stayed high for more than one cycle");
    end

  a_state_onehot: assert property (@(posedge clk) disable iff (!rst)
    $onehot0(state))
    else begin
      fail_count++;
      $error("controller state has more than one bit set");
    end

endmodule

bind flow_ctrl flow_sva flow_sva_inst (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .resume    (resume),
  .error_full(error_full)
);

// File: tests/flow_tb.sv
`timescale 1ns/1ps
`include "flow_config.svh"

module flow_tb;

  localparam int OP_CFG = 0;
  localparam int OP_START = 1;
  localparam int OP_PUSH = 2;
  localparam int OP_DRAIN = 3;
  localparam int OP_WAIT = 4;
  localparam int OP_CHECK = 5;
  localparam int OP_IDLE = 6;
  localparam int OP_RESET = 7;
  localparam int OP_CLR = 8;

  // Flags that WAIT and CHECK rows look at
  localparam int FL_IDLE = 0;
  localparam int FL_PAUSE = 1;
  localparam int FL_ERROR = 2;
  localparam int FL_RESUME = 3;
  localparam int FL_EMPTY = 4;

  localparam int WAIT_LIMIT = 60;
  localparam int MAX_ROWS = 80;

  logic                 clk;
  logic                 rst;
  logic                 reset_req;
  logic                 start;
  logic                 cfg_wr;
  flow_pkg::count_t     cfg_afull;
  flow_pkg::count_t     cfg_aempty;
  logic                 in_push;
  flow_pkg::word_t      in_word;
  flow_pkg::port_mask_t out_pop;
  flow_pkg::payload_t   out_data0;
  flow_pkg::payload_t   out_data1;
  flow_pkg::payload_t   out_data2;
  flow_pkg::payload_t   out_data3;
  flow_pkg::port_mask_t out_empty;
  flow_pkg::port_mask_t pause;
  logic                 resume;
  logic                 idle;
  logic                 error_full;
  logic                 clr_resume;
  logic                 resume_seen;
  int                   checker_errors;

  int     row_op [MAX_ROWS];
  int     row_a [MAX_ROWS];
  int     row_b [MAX_ROWS];
  int     row_exp [MAX_ROWS];
  int     row_test [MAX_ROWS];
  int     num_rows;
  logic   table_ready;
  integer seed;
  int     errors;
  int     passed;
  int     failed;
  int     mark;
  int     cur_test;
  string  test_name [5];

  flow_clkgen clkgen (
    .reset_req(reset_req),
    .clk      (clk),
    .rst      (rst)
  );

  flow_top flow_top_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .cfg_wr    (cfg_wr),
    .cfg_afull (cfg_afull),
    .cfg_aempty(cfg_aempty),
    .in_push   (in_push),
    .in_word   (in_word),
    .out_pop   (out_pop),
    .out_data0 (out_data0),
    .out_data1 (out_data1),
    .out_data2 (out_data2),
    .out_data3 (out_data3),
    .out_empty (out_empty),
    .pause     (pause),
    .resume    (resume),
    .idle      (idle),
    .error_full(error_full)
  );

  flow_checker checker_inst (
    .clk       (clk),
    .rst       (rst),
    .in_push   (in_push),
    .in_word   (in_word),
    .out_pop   (out_pop),
    .out_data0 (out_data0),
    .out_data1 (out_data1),
    .out_data2 (out_data2),
    .out_data3 (out_data3),
    .out_empty (out_empty),
    .mismatches(checker_errors)
  );

  // Resume is a single-cycle pulse, so remember it until cleared
  always @(posedge clk) begin
    if (!rst || clr_resume) begin
      resume_seen <= 1'b0;
    end else if (resume) begin
      resume_seen <= 1'b1;
    end
  end

  function automatic int total_errors();
    return errors + checker_errors + flow_top_inst.ctrl.flow_sva_inst.fail_count;
  endfunction

  function automatic logic flag_value(input int flag, input int idx);
    logic v;
    case (flag)
      FL_IDLE:   v = idle;
      FL_PAUSE:  v = pause[idx];
      FL_ERROR:  v = error_full;
      FL_RESUME: v = resume_seen;
      default:   v = out_empty[idx];
    endcase
    return v;
  endfunction

  function automatic string flag_name(input int flag, input int idx);
    string s;
    case (flag)
      FL_IDLE:   s = "idle";
      FL_PAUSE:  s = $sformatf("pause[%0d]", idx);
      FL_ERROR:  s = "error_full";
      FL_RESUME: s = "resume";
      default:   s = $sformatf("out_empty[%0d]", idx);
    endcase
    return s;
  endfunction

  task automatic add_row(input int test, input int op, input int a, input int b, input int e);
    row_test[num_rows] = test;
    row_op[num_rows] = op;
    row_a[num_rows] = a;
    row_b[num_rows] = b;
    row_exp[num_rows] = e;
    num_rows++;
  endtask

  task automatic wait_flag(input int flag, input int idx, input int e, output logic hit);
    int n;
    hit = 1'b0;
    n = 0;
    while (!hit && n < WAIT_LIMIT) begin
      @(negedge clk);
      if (flag_value(flag, idx) === e[0]) begin
        hit = 1'b1;
      end
      n++;
    end
  endtask

  task automatic apply_row(input int r);
    logic hit;
    @(posedge clk);
    // Strobes last one cycle unless the row sets them again
    cfg_wr <= 1'b0;
    start <= 1'b0;
    in_push <= 1'b0;
    out_pop <= '0;
    clr_resume <= 1'b0;
    case (row_op[r])
      OP_CFG: begin
        cfg_wr <= 1'b1;
        cfg_afull <= flow_pkg::count_t'(row_a[r]);
        cfg_aempty <= flow_pkg::count_t'(row_b[r]);
      end
      OP_START: start <= 1'b1;
      OP_PUSH: begin
        in_push <= 1'b1;
        in_word <= {flow_pkg::dest_t'(row_a[r]), flow_pkg::payload_t'($random(seed))};
      end
      OP_DRAIN: begin
        for (int i = 0; i < row_b[r]; i++) begin
          wait_flag(FL_EMPTY, row_a[r], 0, hit);
          if (!hit) begin
            $display("Port %0d never received an expected word", row_a[r]);
            errors++;
          end else begin
            @(posedge clk);
            out_pop <= flow_pkg::port_mask_t'(1) << row_a[r];
            @(posedge clk);
            out_pop <= '0;
          end
        end
      end
      OP_WAIT: begin
        wait_flag(row_a[r], row_b[r], row_exp[r], hit);
        if (!hit) begin
          $display("Timed out at %0t waiting for %s to become %0d",
                   $time, flag_name(row_a[r], row_b[r]), row_exp[r]);
          errors++;
        end
      end
      OP_CHECK: begin
        @(negedge clk);
        if (flag_value(row_a[r], row_b[r]) !== row_exp[r][0]) begin
          $display("[FAIL] %0t %s got %b expected %0d", $time,
                   flag_name(row_a[r], row_b[r]), flag_value(row_a[r], row_b[r]),
                   row_exp[r]);
          errors++;
        end
      end
      OP_IDLE: repeat (row_b[r]) @(posedge clk);
      OP_RESET: begin
        reset_req <= 1'b1;
        repeat (4) @(posedge clk);
        reset_req <= 1'b0;
      end
      default: clr_resume <= 1'b1;
    endcase
  endtask

  task automatic finish_test(input int t);
    if (total_errors() == mark) begin
      $display("Test %0d %s: ok", t, test_name[t]);
      passed++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", t, test_name[t], total_errors() - mark);
      failed++;
    end
    mark = total_errors();
  endtask

  task automatic build_table();
    // Thresholds 2/1 set in INIT and the later write ignored
    add_row(0, OP_CFG, 2, 1, 0);
    add_row(0, OP_START, 0, 0, 0);
    add_row(0, OP_WAIT, FL_IDLE, 0, 1);
    add_row(0, OP_CFG, 3, 1, 0);
    add_row(0, OP_PUSH, 1, 0, 0);
    add_row(0, OP_PUSH, 1, 0, 0);
    // Both words in port 1 and the input empty again
    add_row(0, OP_WAIT, FL_IDLE, 0, 1);
    // One word for port 0 takes the FSM to ACTIVE where pause rises
    add_row(0, OP_PUSH, 0, 0, 0);
    add_row(0, OP_WAIT, FL_PAUSE, 1, 1);
    // Drain below threshold and forward again
    add_row(1, OP_DRAIN, 1, 2, 0);
    add_row(1, OP_WAIT, FL_PAUSE, 1, 0);
    add_row(1, OP_DRAIN, 0, 1, 0);
    add_row(1, OP_PUSH, 1, 0, 0);
    add_row(1, OP_DRAIN, 1, 1, 0);
    add_row(2, OP_WAIT, FL_IDLE, 0, 1);
    add_row(2, OP_CLR, 0, 0, 0);
    add_row(2, OP_PUSH, 2, 0, 0);
    add_row(2, OP_WAIT, FL_IDLE, 0, 0);
    add_row(2, OP_PUSH, 3, 0, 0);
    add_row(2, OP_PUSH, 3, 0, 0);
    add_row(2, OP_WAIT, FL_RESUME, 0, 1);
    add_row(2, OP_DRAIN, 2, 1, 0);
    add_row(2, OP_DRAIN, 3, 2, 0);
    // Mixed destinations drained in push order
    for (int i = 0; i < 8; i++) begin
      add_row(3, OP_PUSH, i % 4, 0, 0);
    end
    for (int i = 0; i < 8; i++) begin
      add_row(3, OP_DRAIN, i % 4, 1, 0);
    end
    // Port 0 stalled until the input FIFO overflows
    for (int i = 0; i < 12; i++) begin
      add_row(4, OP_PUSH, 0, 0, 0);
    end
    add_row(4, OP_DRAIN, 0, 2, 0);
    add_row(4, OP_WAIT, FL_ERROR, 0, 1);
    add_row(4, OP_IDLE, 0, 10, 0);
    add_row(4, OP_CHECK, FL_ERROR, 0, 1);
    add_row(4, OP_RESET, 0, 0, 0);
    add_row(4, OP_CHECK, FL_ERROR, 0, 0);
    add_row(4, OP_PUSH, 2, 0, 0);
    add_row(4, OP_IDLE, 0, 10, 0);
    add_row(4, OP_CHECK, FL_EMPTY, 2, 1);
    add_row(4, OP_START, 0, 0, 0);
    add_row(4, OP_DRAIN, 2, 1, 0);
    add_row(4, OP_CHECK, FL_ERROR, 0, 0);
  endtask

  initial begin
    start = 1'b0;
    cfg_wr = 1'b0;
    cfg_afull = '0;
    cfg_aempty = '0;
    in_push = 1'b0;
    in_word = '0;
    out_pop = '0;
    clr_resume = 1'b0;
    reset_req = 1'b0;
    seed = 86397;
    errors = 0;
    passed = 0;
    failed = 0;
    mark = 0;
    num_rows = 0;
    test_name[0] = "config window";
    test_name[1] = "pause and release";
    test_name[2] = "idle and resume";
    test_name[3] = "routing order";
    test_name[4] = "overflow and restart";
    build_table();
    table_ready = 1'b1;
    wait (rst === 1'b1);
    cur_test = row_test[0];
    for (int r = 0; r < num_rows; r++) begin
      if (row_test[r] != cur_test) begin
        finish_test(cur_test);
        cur_test = row_test[r];
      end
      apply_row(r);
    end
    repeat (5) @(posedge clk);
    finish_test(cur_test);
    $display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed,
             total_errors());
    if (failed == 0 && total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Budget of 50 cycles per table row
  initial begin
    wait (table_ready === 1'b1);
    repeat (num_rows * 50) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             num_rows * 50);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
source/flow_pkg.sv
source/flow_fifo.sv
source/vc_router.sv
source/flow_ctrl.sv
source/flow_top.sv
tests/flow_clkgen.sv
tests/flow_checker.sv
tests/flow_sva.sv
tests/flow_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= flow_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard source/*.sv tests/*.sv include/*.svh) project.f
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f project.f

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
